// File: verilog/spi_cmd_pkg.sv
package spi_cmd_pkg;

  //**************************************************************************
  // Field widths.
  //**************************************************************************
  localparam int SPI_ADDR_WIDTH = 3;
  localparam int SPI_DATA_WIDTH = 8;
  localparam int SPI_CMD_WIDTH = 1 + SPI_ADDR_WIDTH + SPI_DATA_WIDTH;

  // Flag and address only.
  localparam int SPI_READ_HDR_BITS = 1 + SPI_ADDR_WIDTH;

  //**************************************************************************
  // Timing, in clk cycles.
  //**************************************************************************
  localparam int SPI_SCLK_HALF = 4;
  localparam int SPI_BIT_CYCLES = 2 * SPI_SCLK_HALF;
  localparam int SPI_READ_GAP = 100;

  localparam int CMD_FIFO_DEPTH = 4;

  // Counter widths.
  localparam int SPI_PHASE_WIDTH = $clog2(SPI_BIT_CYCLES);
  localparam int SPI_BIT_CNT_WIDTH = $clog2(SPI_CMD_WIDTH);
  localparam int SPI_GAP_CNT_WIDTH = $clog2(SPI_READ_GAP);
  localparam int CMD_FIFO_PTR_WIDTH = $clog2(CMD_FIFO_DEPTH);

  //**************************************************************************
  // Types.
  //**************************************************************************
  typedef logic [SPI_ADDR_WIDTH-1:0] spi_addr_t;
  typedef logic [SPI_DATA_WIDTH-1:0] spi_data_t;

  typedef logic [SPI_PHASE_WIDTH-1:0] spi_phase_t;
  typedef logic [SPI_BIT_CNT_WIDTH-1:0] spi_bit_cnt_t;
  typedef logic [SPI_GAP_CNT_WIDTH-1:0] spi_gap_cnt_t;

  typedef logic [CMD_FIFO_PTR_WIDTH-1:0] cmd_fifo_ptr_t;
  typedef logic [CMD_FIFO_PTR_WIDTH:0] cmd_fifo_cnt_t;

  // Bit 11 write flag, bits 10..8 address, bits 7..0 data.
  typedef struct packed {
    logic      write;
    spi_addr_t addr;
    spi_data_t data;
  } spi_cmd_t;

endpackage

// File: verilog/spi_cmd_builder.sv
`timescale 1ns/10ps

module spi_cmd_builder (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_stb,
  input  logic                  rd_stb,
  input  spi_cmd_pkg::spi_addr_t addr,
  input  spi_cmd_pkg::spi_data_t wdata,
  input  logic                  full,
  output logic                  busy,
  output logic                  push,
  output spi_cmd_pkg::spi_cmd_t  cmd
);

  import spi_cmd_pkg::*;

  spi_cmd_t new_cmd;
  logic     stb;
  logic     pend_q;

  assign stb = wr_stb | rd_stb;

  // Reads carry no data.
  always_comb
  begin
    new_cmd.write = wr_stb;
    new_cmd.addr = addr;
    new_cmd.data = wr_stb ? wdata : '0;
  end

  //**************************************************************************
  // Pending slot.
  //**************************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pend_q <= 1'b0;
    end
    else if (stb)
    begin
      pend_q <= 1'b1;
    end
    else if (push)
    begin
      pend_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (stb)
    begin
      cmd <= new_cmd;
    end
  end

  // Word leaves as soon as the FIFO has room.
  assign push = pend_q & ~full;

  // Host holds off while a word waits on a full FIFO.
  assign busy = pend_q & full;

endmodule

// File: verilog/spi_cmd_fifo.sv
`timescale 1ns/10ps

module spi_cmd_fifo (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 push,
  input  spi_cmd_pkg::spi_cmd_t cmd,
  input  logic                 pop,
  output spi_cmd_pkg::spi_cmd_t head,
  output logic                 full,
  output logic                 empty
);

  import spi_cmd_pkg::*;

  spi_cmd_t      mem [CMD_FIFO_DEPTH];
  cmd_fifo_ptr_t wr_ptr_q;
  cmd_fifo_ptr_t rd_ptr_q;
  cmd_fifo_cnt_t count_q;
  logic          wr_en;
  logic          rd_en;

  assign full = (count_q == CMD_FIFO_DEPTH);
  assign empty = (count_q == '0);

  // A pop frees the slot the push needs.
  assign wr_en = push & (~full | pop);
  assign rd_en = pop & ~empty;

  // Show-ahead.
  assign head = mem[rd_ptr_q];

  always_ff @(posedge clk)
  begin
    if (wr_en)
    begin
      mem[wr_ptr_q] <= cmd;
    end
  end

  //**************************************************************************
  // Pointers and occupancy.
  //**************************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q <= '0;
    end
    else
    begin
      if (wr_en)
      begin
        wr_ptr_q <= (wr_ptr_q == CMD_FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en)
      begin
        rd_ptr_q <= (rd_ptr_q == CMD_FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count_q <= count_q + 1'b1;
        2'b01: count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: verilog/spi_master.sv
`timescale 1ns/10ps

module spi_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  spi_cmd_pkg::spi_cmd_t  head,
  input  logic                  empty,
  input  logic                  miso,
  output logic                  pop,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  read_vld,
  output spi_cmd_pkg::spi_data_t read_data
);

  import spi_cmd_pkg::*;

  typedef enum logic [2:0] {
    idle,
    write_shift,
    read_hdr,
    read_gap,
    read_shift,
    frame_end
  } state_t;

  state_t                   state_q;
  spi_phase_t               phase_q;
  spi_bit_cnt_t             bit_q;
  spi_gap_cnt_t             gap_q;
  spi_bit_cnt_t             last_idx;
  logic                     shifting;
  logic                     bit_end;
  logic                     last_bit;
  logic [SPI_CMD_WIDTH-1:0] tx_shift_q;
  spi_data_t                rx_shift_q;

  // Take a word only between frames.
  assign pop = (state_q == idle) & ~empty;

  assign shifting = (state_q == write_shift) | (state_q == read_hdr) |
                    (state_q == read_shift);

  assign bit_end = (phase_q == SPI_BIT_CYCLES - 1);

  // Frame length depends on the phase of the transaction.
  always_comb
  begin
    case (state_q)
      write_shift: last_idx = spi_bit_cnt_t'(SPI_CMD_WIDTH - 1);
      read_hdr: last_idx = spi_bit_cnt_t'(SPI_READ_HDR_BITS - 1);
      default: last_idx = spi_bit_cnt_t'(SPI_DATA_WIDTH - 1);
    endcase
  end

  assign last_bit = (bit_q == last_idx);

  //**************************************************************************
  // Control FSM and pins.
  //**************************************************************************
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q <= idle;
      phase_q <= '0;
      bit_q <= '0;
      gap_q <= '0;
      sclk <= 1'b0;
      cs_n <= 1'b1;
      mosi <= 1'b0;
      read_vld <= 1'b0;
    end
    else
    begin
      read_vld <= 1'b0;
      case (state_q)
        idle:
        begin
          if (pop)
          begin
            // First bit is on mosi when cs_n falls.
            cs_n <= 1'b0;
            mosi <= head.write;
            phase_q <= '0;
            bit_q <= '0;
            state_q <= head.write ? write_shift : read_hdr;
          end
        end
        write_shift, read_hdr, read_shift:
        begin
          // Rising edge at mid bit.
          if (phase_q == SPI_SCLK_HALF - 1)
          begin
            sclk <= 1'b1;
          end
          if (bit_end)
          begin
            sclk <= 1'b0;
            phase_q <= '0;
            if (last_bit)
            begin
              cs_n <= 1'b1;
              mosi <= 1'b0;
              bit_q <= '0;
              if (state_q == read_hdr)
              begin
                gap_q <= '0;
                state_q <= read_gap;
              end
              else
              begin
                read_vld <= (state_q == read_shift);
                state_q <= frame_end;
              end
            end
            else
            begin
              bit_q <= bit_q + 1'b1;
              // Next bit goes out with the falling edge.
              if (state_q != read_shift)
              begin
                mosi <= tx_shift_q[SPI_CMD_WIDTH-2];
              end
            end
          end
          else
          begin
            phase_q <= phase_q + 1'b1;
          end
        end
        read_gap:
        begin
          if (gap_q == SPI_READ_GAP - 1)
          begin
            cs_n <= 1'b0;
            state_q <= read_shift;
          end
          else
          begin
            gap_q <= gap_q + 1'b1;
          end
        end
        frame_end:
        begin
          state_q <= idle;
        end
        default:
        begin
          state_q <= idle;
        end
      endcase
    end
  end

  //**************************************************************************
  // Shift registers and read data.
  //**************************************************************************
  always_ff @(posedge clk)
  begin
    if (pop)
    begin
      tx_shift_q <= head;
    end
    else if (shifting && bit_end)
    begin
      tx_shift_q <= {tx_shift_q[SPI_CMD_WIDTH-2:0], 1'b0};
    end

    // Sample on the edge that raises sclk.
    if ((state_q == read_shift) && (phase_q == SPI_SCLK_HALF - 1))
    begin
      rx_shift_q <= {rx_shift_q[SPI_DATA_WIDTH-2:0], miso};
    end

    if ((state_q == read_shift) && bit_end && last_bit)
    begin
      read_data <= rx_shift_q;
    end
  end

endmodule

// File: verilog/spi_cmd_top.sv
`timescale 1ns/10ps

module spi_cmd_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_stb,
  input  logic                  rd_stb,
  input  spi_cmd_pkg::spi_addr_t addr,
  input  spi_cmd_pkg::spi_data_t wdata,
  input  logic                  miso,
  output logic                  busy,
  output logic                  sclk,
  output logic                  cs_n,
  output logic                  mosi,
  output logic                  read_vld,
  output spi_cmd_pkg::spi_data_t read_data
);

  import spi_cmd_pkg::*;

  spi_cmd_t cmd;
  spi_cmd_t head;
  logic     push;
  logic     pop;
  logic     full;
  logic     empty;

  //**************************************************************************
  // Host strobes to command words.
  //**************************************************************************
  spi_cmd_builder spi_cmd_builder_inst (
    .clk   (clk),
    .rst_n (rst_n),
    .wr_stb(wr_stb),
    .rd_stb(rd_stb),
    .addr  (addr),
    .wdata (wdata),
    .full  (full),
    .busy  (busy),
    .push  (push),
    .cmd   (cmd)
  );

  spi_cmd_fifo spi_cmd_fifo_inst (
    .clk  (clk),
    .rst_n(rst_n),
    .push (push),
    .cmd  (cmd),
    .pop  (pop),
    .head (head),
    .full (full),
    .empty(empty)
  );

  // Wire side.
  spi_master spi_master_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .head     (head),
    .empty    (empty),
    .miso     (miso),
    .pop      (pop),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .read_vld (read_vld),
    .read_data(read_data)
  );

endmodule

// File: verif/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int HALF_PERIOD = 5;
  localparam int RESET_CYCLES = 10;

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #HALF_PERIOD clk = ~clk;
    end
  end

  // Reset is released on a rising edge.
  initial
  begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule

// File: verif/spi_slave_model.sv
`timescale 1ns/10ps

module spi_slave_model (
  input  logic sclk,
  input  logic cs_n,
  input  logic mosi,
  output logic miso
);

  import spi_cmd_pkg::*;

  localparam int REG_COUNT = 1 << SPI_ADDR_WIDTH;

  spi_data_t                regs [REG_COUNT];
  logic [SPI_CMD_WIDTH-1:0] rx_bits;
  int                       bit_cnt;
  int                       tx_idx;
  spi_addr_t                rd_addr;
  logic                     rd_pending;
  logic                     cs_n_q;
  logic                     sclk_q;

  initial
  begin
    for (int i = 0; i < REG_COUNT; i++)
    begin
      regs[i] = '0;
    end
    miso = 1'b0;
    rx_bits = '0;
    bit_cnt = 0;
    tx_idx = -1;
    rd_addr = '0;
    rd_pending = 1'b0;
    cs_n_q = 1'b1;
    sclk_q = 1'b0;
  end

  // Read data goes out MSB first.
  task automatic drive_next_bit();
    if (rd_pending && (tx_idx >= 0))
    begin
      miso = regs[rd_addr][tx_idx];
      tx_idx--;
    end
  endtask

  task automatic start_frame();
    bit_cnt = 0;
    rx_bits = '0;
    if (rd_pending)
    begin
      tx_idx = SPI_DATA_WIDTH - 1;
      drive_next_bit();
    end
  endtask

  //**************************************************************************
  // Frame decode at cs_n rise.
  //**************************************************************************
  task automatic end_frame();
    if ((bit_cnt == SPI_CMD_WIDTH) && rx_bits[SPI_CMD_WIDTH-1])
    begin
      regs[rx_bits[SPI_CMD_WIDTH-2 -: SPI_ADDR_WIDTH]] = rx_bits[SPI_DATA_WIDTH-1:0];
    end
    else if ((bit_cnt == SPI_READ_HDR_BITS) && !rx_bits[SPI_READ_HDR_BITS-1])
    begin
      rd_addr = rx_bits[SPI_ADDR_WIDTH-1:0];
      rd_pending = 1'b1;
    end
    else if (bit_cnt == SPI_DATA_WIDTH)
    begin
      rd_pending = 1'b0;
    end
    miso = 1'b0;
  endtask

  always @(sclk or cs_n)
  begin
    if (cs_n && !cs_n_q)
    begin
      end_frame();
    end
    else if (!cs_n && cs_n_q)
    begin
      start_frame();
    end
    else if (!cs_n && sclk && !sclk_q)
    begin
      rx_bits = {rx_bits[SPI_CMD_WIDTH-2:0], mosi};
      bit_cnt++;
    end
    else if (!cs_n && !sclk && sclk_q)
    begin
      drive_next_bit();
    end
    cs_n_q = cs_n;
    sclk_q = sclk;
  end

endmodule

// File: verif/spi_cmd_properties.sv
`timescale 1ns/10ps

module spi_cmd_properties (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  wr_stb,
  input logic                  rd_stb,
  input logic                  busy,
  input logic                  sclk,
  input logic                  cs_n,
  input logic                  mosi,
  input logic                  read_vld,
  input logic                  pop,
  input spi_cmd_pkg::spi_cmd_t head
);

  import spi_cmd_pkg::*;

  typedef enum logic [1:0] {
    frame_write,
    frame_hdr,
    frame_data
  } frame_kind_t;

  int          frame_fail_count = 0;
  int          protocol_fail_count = 0;
  int          low_cnt;
  int          high_cnt;
  logic        cs_n_d;
  frame_kind_t kind;

  function automatic int frame_cycles(frame_kind_t k);
    case (k)
      frame_write: return SPI_CMD_WIDTH * SPI_BIT_CYCLES;
      frame_hdr: return SPI_READ_HDR_BITS * SPI_BIT_CYCLES;
      default: return SPI_DATA_WIDTH * SPI_BIT_CYCLES;
    endcase
  endfunction

  // Kind of the frame in flight, and run lengths of cs_n.
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      low_cnt <= 0;
      high_cnt <= 0;
      cs_n_d <= 1'b1;
      kind <= frame_write;
    end
    else
    begin
      cs_n_d <= cs_n;
      low_cnt <= cs_n ? 0 : low_cnt + 1;
      high_cnt <= cs_n ? high_cnt + 1 : 0;
      if (pop)
      begin
        kind <= head.write ? frame_write : frame_hdr;
      end
      else if (cs_n && !cs_n_d && (kind == frame_hdr))
      begin
        kind <= frame_data;
      end
    end
  end

  //**************************************************************************
  // Frame shape.
  //**************************************************************************
  a_frame_len: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(cs_n) |-> (low_cnt == frame_cycles(kind)))
  else
  begin
    frame_fail_count++;
    $error("cs_n was low for %0d cycles", low_cnt);
  end

  a_read_gap: assert property (@(posedge clk) disable iff (!rst_n)
    ($fell(cs_n) && (kind == frame_data)) |-> (high_cnt == SPI_READ_GAP))
  else
  begin
    frame_fail_count++;
    $error("read gap lasted %0d cycles", high_cnt);
  end

  a_sclk_idle: assert property (@(posedge clk) disable iff (!rst_n)
    cs_n |-> !sclk)
  else
  begin
    frame_fail_count++;
    $error("sclk high while cs_n is high");
  end

  a_sclk_toggle: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(sclk) |-> !$past(cs_n))
  else
  begin
    frame_fail_count++;
    $error("sclk toggled outside a frame");
  end

  a_mosi_stable: assert property (@(posedge clk) disable iff (!rst_n)
    sclk |-> $stable(mosi))
  else
  begin
    frame_fail_count++;
    $error("mosi changed while sclk is high");
  end

  //**************************************************************************
  // Reset and host protocol.
  //**************************************************************************
  a_reset_state: assert property (@(posedge clk)
    !rst_n |=> (cs_n && !sclk && !mosi && !read_vld && !busy))
  else
  begin
    protocol_fail_count++;
    $error("outputs not at reset values");
  end

  a_no_stb_busy: assert property (@(posedge clk) disable iff (!rst_n)
    busy |-> !(wr_stb || rd_stb))
  else
  begin
    protocol_fail_count++;
    $error("host strobe while busy");
  end

  a_vld_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_vld |=> !read_vld)
  else
  begin
    protocol_fail_count++;
    $error("read_vld high for two cycles");
  end

endmodule

bind spi_cmd_top spi_cmd_properties spi_cmd_properties_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .wr_stb  (wr_stb),
  .rd_stb  (rd_stb),
  .busy    (busy),
  .sclk    (sclk),
  .cs_n    (cs_n),
  .mosi    (mosi),
  .read_vld(read_vld),
  .pop     (pop),
  .head    (head)
);

// File: verif/spi_cmd_tb.sv
`timescale 1ns/10ps

module spi_cmd_tb;

  import spi_cmd_pkg::*;

  // About 40 transactions, a read being the longest at roughly 200 cycles.
  localparam int TXN_COUNT = 40;
  localparam int TXN_CYCLES = 200;
  localparam int TIMEOUT_CYCLES = 5 * TXN_COUNT * TXN_CYCLES;
  localparam int RANDOM_OPS = 24;
  localparam int REG_COUNT = 1 << SPI_ADDR_WIDTH;

  logic      clk;
  logic      rst_n;
  logic      wr_stb;
  logic      rd_stb;
  spi_addr_t addr;
  spi_data_t wdata;
  logic      miso;
  logic      busy;
  logic      sclk;
  logic      cs_n;
  logic      mosi;
  logic      read_vld;
  spi_data_t read_data;

  spi_data_t shadow [REG_COUNT];
  spi_data_t pending_reads [$];
  int        frames_issued = 0;
  int        frames_done = 0;
  int        vld_count = 0;
  int        error_count = 0;
  int        tests_passed = 0;
  int        tests_failed = 0;
  int        cycle_count = 0;
  logic      busy_seen = 1'b0;
  logic      cs_n_d = 1'b1;
  integer    seed;

  tb_clock_gen tb_clock_gen_inst (
    .clk  (clk),
    .rst_n(rst_n)
  );

  spi_slave_model spi_slave_model_inst (
    .sclk(sclk),
    .cs_n(cs_n),
    .mosi(mosi),
    .miso(miso)
  );

  spi_cmd_top spi_cmd_top_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_stb   (wr_stb),
    .rd_stb   (rd_stb),
    .addr     (addr),
    .wdata    (wdata),
    .miso     (miso),
    .busy     (busy),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .mosi     (mosi),
    .read_vld (read_vld),
    .read_data(read_data)
  );

  //**************************************************************************
  // Host side.
  //**************************************************************************
  task automatic wait_not_busy();
    @(posedge clk);
    while (busy)
    begin
      busy_seen = 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic write_reg(input spi_addr_t a, input spi_data_t d);
    wait_not_busy();
    wr_stb <= 1'b1;
    addr <= a;
    wdata <= d;
    shadow[a] = d;
    frames_issued++;
    @(posedge clk);
    wr_stb <= 1'b0;
  endtask

  // Expected value is the shadow at issue time.
  task automatic read_reg(input spi_addr_t a);
    wait_not_busy();
    rd_stb <= 1'b1;
    addr <= a;
    pending_reads.push_back(shadow[a]);
    frames_issued += 2;
    @(posedge clk);
    rd_stb <= 1'b0;
  endtask

  task automatic wait_idle();
    while ((frames_done != frames_issued) || (pending_reads.size() != 0))
    begin
      @(posedge clk);
    end
  endtask

  task automatic finish_test(input string name, input int errors_before);
    if (error_count == errors_before)
    begin
      tests_passed++;
      $display("%s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d errors", name, error_count - errors_before);
    end
  endtask

  task automatic report_property_test(input string name, input int fails);
    if (fails == 0)
    begin
      tests_passed++;
      $display("%s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("%s: failed with %0d assertion failures", name, fails);
    end
  endtask

  //**************************************************************************
  // Read data and frame monitor.
  //**************************************************************************
  task automatic check_read();
    spi_data_t want;
    vld_count++;
    assert (pending_reads.size() != 0)
    else
    begin
      $display("read_vld pulsed with no read outstanding");
      error_count++;
    end
    if (pending_reads.size() != 0)
    begin
      want = pending_reads.pop_front();
      assert (read_data == want)
      else
      begin
        $display("mismatch read_data expected %h actual %h", want, read_data);
        error_count++;
      end
    end
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      if (cs_n && !cs_n_d)
      begin
        frames_done++;
      end
      if (read_vld)
      begin
        check_read();
      end
    end
    cs_n_d = cs_n;
  end

  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("** FAIL **");
      $finish;
    end
  end

  //**************************************************************************
  // Tests.
  //**************************************************************************
  initial
  begin
    int     mark;
    int     vld_mark;
    int     i;
    integer rnd;
    spi_addr_t a;
    spi_data_t d;

    seed = 32'h52db;
    wr_stb = 1'b0;
    rd_stb = 1'b0;
    addr = '0;
    wdata = '0;
    // Slave registers start at zero.
    for (i = 0; i < REG_COUNT; i++)
    begin
      shadow[i] = '0;
    end
    wait (rst_n === 1'b1);

    mark = error_count;
    vld_mark = vld_count;
    write_reg(3'd5, 8'ha5);
    read_reg(3'd5);
    wait_idle();
    assert (vld_count - vld_mark == 1)
    else
    begin
      $display("read_vld pulsed %0d times for one read", vld_count - vld_mark);
      error_count++;
    end
    finish_test("test 1 single write then read", mark);

    mark = error_count;
    busy_seen = 1'b0;
    for (i = 0; i < REG_COUNT; i++)
    begin
      write_reg(spi_addr_t'(i), spi_data_t'((i + 1) * 17));
    end
    assert (busy_seen)
    else
    begin
      $display("busy never went high during the burst write");
      error_count++;
    end
    for (i = 0; i < REG_COUNT; i++)
    begin
      read_reg(spi_addr_t'(i));
    end
    wait_idle();
    finish_test("test 2 burst write under back-pressure", mark);

    mark = error_count;
    for (i = 0; i < RANDOM_OPS; i++)
    begin
      rnd = $random(seed);
      a = rnd[SPI_ADDR_WIDTH+7:8];
      d = rnd[SPI_DATA_WIDTH+15:16];
      if (rnd[0])
      begin
        write_reg(a, d);
      end
      else
      begin
        read_reg(a);
      end
    end
    wait_idle();
    finish_test("test 3 interleaved reads and writes", mark);

    report_property_test("test 4 frame shape",
                         spi_cmd_top_inst.spi_cmd_properties_inst.frame_fail_count);
    report_property_test("test 5 reset and protocol",
                         spi_cmd_top_inst.spi_cmd_properties_inst.protocol_fail_count);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0)
    begin
      $display("** PASS **");
    end
    else
    begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tb.f
verilog/spi_cmd_pkg.sv
verilog/spi_cmd_builder.sv
verilog/spi_cmd_fifo.sv
verilog/spi_master.sv
verilog/spi_cmd_top.sv
verif/tb_clock_gen.sv
verif/spi_slave_model.sv
verif/spi_cmd_properties.sv
verif/spi_cmd_tb.sv

// File: Bender.yml
package:
  name: spi_cmd

sources:
  - files:
      - verilog/spi_cmd_pkg.sv
      - verilog/spi_cmd_builder.sv
      - verilog/spi_cmd_fifo.sv
      - verilog/spi_master.sv
      - verilog/spi_cmd_top.sv
  - target: test
    files:
      - verif/tb_clock_gen.sv
      - verif/spi_slave_model.sv
      - verif/spi_cmd_properties.sv
      - verif/spi_cmd_tb.sv
